// ==== mipsSystem.f ====
+incdir+bench
design/mipsIsaPkg.sv
design/mipsCtrlPkg.sv
design/aluDecoder.sv
design/controlUnit.sv
design/datapath.sv
design/memArbiter.sv
design/unifiedMemory.sv
design/mipsSystem.sv
bench/mipsSystemTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/100ps --top-module mipsSystemTb \
	-f mipsSystem.f -o mipsSim
./obj_dir/mipsSim | tee sim.log
if grep -q "Test FAILED" sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi
grep -q "Test OK" sim.log

// ==== bench/mipsTests.svh ====
`ifndef MIPS_TESTS_SVH
`define MIPS_TESTS_SVH

// Operands at word 0x80, results at word 0xc0
localparam logic [7:0] DataBase = 8'h80;
localparam logic [7:0] ResultBase = 8'hc0;
localparam logic [15:0] DataByte = 16'h0200;
localparam logic [15:0] ResultByte = 16'h0300;
localparam int ResultSlots = 16;

word_t expected [ResultSlots];
word_t dataWords [8];
logic [7:0] progAddr;
int runCycles;

function automatic word_t rEnc(input funct_e f, input logic [4:0] rs, rt, rd, sh);
	return {RType, rs, rt, rd, sh, f};
endfunction

function automatic word_t iEnc(input opcode_e op, input logic [4:0] rs, rt,
		input logic [15:0] imm);
	return {op, rs, rt, imm};
endfunction

function automatic word_t jEnc(input opcode_e op, input logic [25:0] index);
	return {op, index};
endfunction

// Cycles from one PreFetch to the next
function automatic int cyclesOf(input word_t w);
	case (opcode_e'(w[31:26]))
		Lw: return 6;
		Beq, Bne, J, Jal: return 4;
		default: return 5;
	endcase
endfunction

function automatic word_t poison(input logic [7:0] addr);
	return {16'hdead, ~addr, addr};
endfunction

// R-type semantics, shifts act on rt
function automatic word_t refR(input funct_e f, input word_t a, b, input logic [4:0] sh);
	case (f)
		Add: return a + b;
		Sub: return a - b;
		And: return a & b;
		Or: return a | b;
		Xor: return a ^ b;
		Nor: return ~(a | b);
		Slt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		Sll: return b << sh;
		Srl: return b >> sh;
		default: return word_t'($signed(b) >>> sh);
	endcase
endfunction

function automatic word_t refI(input opcode_e op, input word_t a, input logic [15:0] imm);
	word_t sext;
	word_t zext;
	sext = {{16{imm[15]}}, imm};
	zext = {16'h0000, imm};
	case (op)
		Addi: return a + sext;
		Slti: return ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
		Andi: return a & zext;
		Ori: return a | zext;
		Xori: return a ^ zext;
		default: return {imm, 16'h0000};
	endcase
endfunction

task automatic emit(input word_t w, input bit runs = 1'b1);
	hostWrite(progAddr, w);
	progAddr++;
	if (runs)
		runCycles += cyclesOf(w);
endtask

task automatic startTest(input string name);
	int k;
	testName = name;
	rstb = 1'b0;
	progAddr = '0;
	runCycles = 0;
	// Poisoned result area makes a missing store visible
	for (k = 0; k < ResultSlots; k++) begin
		expected[k] = poison(ResultBase + 8'(k));
		hostWrite(ResultBase + 8'(k), expected[k]);
	end
endtask

task automatic loadData();
	int k;
	for (k = 0; k < 8; k++) begin
		dataWords[k] = randBits(32);
		hostWrite(DataBase + 8'(k), dataWords[k]);
	end
endtask

task automatic releaseCore();
	// Halt loop jumps to its own address
	emit(jEnc(J, 26'(progAddr)), 1'b0);
	waitCycles(ResetCycles);
	rstb = 1'b1;
endtask

task automatic checkResults();
	word_t got;
	int k;
	for (k = 0; k < ResultSlots; k++) begin
		hostRead(ResultBase + 8'(k), got);
		checkWord($sformatf("slot %0d", k), expected[k], got);
	end
endtask

task automatic runAndCheck();
	releaseCore();
	waitCycles(runCycles);
	checkResults();
endtask

task automatic rtypeTest(input string name, input int hostReads);
	funct_e ops [10];
	logic [4:0] sh;
	logic [2:0] idx;
	word_t got;
	int k;
	int gap;
	int elapsed;
	ops = '{Add, Sub, And, Or, Xor, Nor, Slt, Sll, Srl, Sra};
	startTest(name);
	loadData();
	emit(iEnc(Lw, 0, 1, DataByte));
	emit(iEnc(Lw, 0, 2, DataByte + 16'd4));
	for (k = 0; k < 10; k++) begin
		sh = (ops[k] inside {Sll, Srl, Sra}) ? 5'(randBits(5)) : 5'd0;
		emit(rEnc(ops[k], 1, 2, 3, sh));
		emit(iEnc(Sw, 0, 3, ResultByte + 16'(4 * k)));
		expected[k] = refR(ops[k], dataWords[0], dataWords[1], sh);
	end
	releaseCore();
	elapsed = 0;
	for (k = 0; k < hostReads; k++) begin
		gap = int'(randBits(3));
		waitCycles(gap);
		idx = 3'(randBits(3));
		hostRead(DataBase + 8'(idx), got);
		checkWord($sformatf("host read %02h", DataBase + 8'(idx)), dataWords[idx], got);
		elapsed += gap + 1;
	end
	// Every host read stalls the core one cycle
	waitCycles(runCycles + hostReads - elapsed);
	checkResults();
endtask

task automatic itypeTest();
	opcode_e ops [6];
	logic [15:0] imm;
	int k;
	ops = '{Addi, Slti, Andi, Ori, Xori, Lui};
	startTest("itype");
	loadData();
	emit(iEnc(Lw, 0, 1, DataByte));
	for (k = 0; k < 6; k++) begin
		// Top bit set so sign and zero extension differ
		imm = {1'b1, 15'(randBits(15))};
		emit(iEnc(ops[k], 1, 3, imm));
		emit(iEnc(Sw, 0, 3, ResultByte + 16'(4 * k)));
		expected[k] = refI(ops[k], dataWords[0], imm);
	end
	runAndCheck();
endtask

task automatic loadStoreTest();
	startTest("load store");
	loadData();
	emit(iEnc(Addi, 0, 5, DataByte));
	emit(iEnc(Addi, 0, 6, 16'h0320));
	emit(iEnc(Lw, 5, 1, 16'h0000));
	emit(iEnc(Sw, 5, 1, 16'h0100));
	emit(iEnc(Lw, 5, 2, 16'h0008));
	// Negative offsets from 0x320
	emit(iEnc(Sw, 6, 2, 16'hffe4));
	emit(iEnc(Lw, 6, 3, 16'hfeec));
	emit(iEnc(Sw, 6, 3, 16'hffe8));
	// r0 ignores the load
	emit(iEnc(Lw, 5, 0, 16'h0004));
	emit(iEnc(Sw, 5, 0, 16'h010c));
	expected[0] = dataWords[0];
	expected[1] = dataWords[2];
	expected[2] = dataWords[3];
	expected[3] = '0;
	runAndCheck();
endtask

task automatic branchTest();
	opcode_e ops [4];
	int rtSel [4];
	int regVal [4];
	bit taken;
	int k;
	ops = '{Beq, Beq, Bne, Bne};
	rtSel = '{2, 3, 3, 2};
	regVal = '{0, 5, 5, 7};
	startTest("branch");
	emit(iEnc(Addi, 0, 1, 16'd5));
	emit(iEnc(Addi, 0, 2, 16'd5));
	emit(iEnc(Addi, 0, 3, 16'd7));
	for (k = 0; k < 4; k++)
		emit(iEnc(Addi, 0, 5'(4 + k), 16'h0a10 + 16'(k)));
	for (k = 0; k < 4; k++) begin
		if (ops[k] == Beq)
			taken = (regVal[1] == regVal[rtSel[k]]);
		else
			taken = (regVal[1] != regVal[rtSel[k]]);
		// Offset 1 skips the fall-through store
		emit(iEnc(ops[k], 1, 5'(rtSel[k]), 16'd1));
		emit(iEnc(Sw, 0, 5'(4 + k), ResultByte + 16'(8 * k)), !taken);
		emit(iEnc(Sw, 0, 5'(4 + k), ResultByte + 16'(8 * k + 4)));
		if (!taken)
			expected[2 * k] = 32'h0a10 + 32'(k);
		expected[2 * k + 1] = 32'h0a10 + 32'(k);
	end
	runAndCheck();
endtask

task automatic jumpTest();
	startTest("jump");
	emit(iEnc(Addi, 0, 1, 16'h001f));
	emit(jEnc(J, 26'd3));
	emit(iEnc(Sw, 0, 1, ResultByte), 1'b0);
	emit(jEnc(Jal, 26'd6));
	// jr lands here
	emit(iEnc(Sw, 0, RegLink, ResultByte + 16'd4));
	emit(jEnc(J, 26'd5), 1'b0);
	emit(iEnc(Sw, 0, RegLink, ResultByte + 16'd8));
	emit(rEnc(Jr, RegLink, 0, 0, 0));
	// Link is the byte address of jal plus 4
	expected[1] = 32'd3 * 32'd4 + 32'd4;
	expected[2] = 32'd3 * 32'd4 + 32'd4;
	runAndCheck();
endtask

`endif

// ==== bench/mipsSystemTb.sv ====
module mipsSystemTb;
	timeunit 1ns;
	timeprecision 100ps;

	import mipsIsaPkg::*;
	import mipsCtrlPkg::*;

	localparam int ResetCycles = 8;
	// Summed length of the six tests, loading and readback included
	localparam int TestCycles = 832;
	localparam int CycleLimit = 2 * TestCycles + ResetCycles;

	logic cclk;
	logic rstb;
	hostReq_t host;
	word_t hostRdata;
	logic [31:0] lfsr;
	int cycleCount;
	int checkCount;
	int errorCount;
	string testName;

	mipsSystem dut_i (
		.cclk(cclk),
		.rstb(rstb),
		.host(host),
		.hostRdata(hostRdata)
	);

	initial begin
		cclk = 1'b0;
		forever #5 cclk = ~cclk;
	end

	always @(posedge cclk) begin
		cycleCount++;
		if (cycleCount > CycleLimit) begin
			$display("Timeout, the run went past %0d cycles", CycleLimit);
			$display("Test FAILED");
			$finish;
		end
	end

	// Fibonacci LFSR, taps 32 22 2 1, one step per bit
	function automatic word_t randBits(input int n);
		word_t v;
		logic fb;
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	task automatic waitCycles(input int n);
		repeat (n) begin
			@(posedge cclk);
			#1;
		end
	endtask

	task automatic hostWrite(input logic [7:0] addr, input word_t data);
		host.valid = 1'b1;
		host.write = 1'b1;
		host.addr = addr;
		host.wdata = data;
		waitCycles(1);
		host = '0;
	endtask

	task automatic hostRead(input logic [7:0] addr, output word_t data);
		host.valid = 1'b1;
		host.write = 1'b0;
		host.addr = addr;
		host.wdata = '0;
		// Combinational read, settled well before the edge
		#1;
		data = hostRdata;
		@(posedge cclk);
		#1;
		host = '0;
	endtask

	task automatic checkWord(input string what, input word_t exp, input word_t act);
		checkCount++;
		if (act !== exp) begin
			errorCount++;
			$display("** Error %s, %s: expected %08h, actual %08h", testName, what, exp, act);
		end
	endtask

	`include "mipsTests.svh"

	initial begin
		host = '0;
		rstb = 1'b0;
		lfsr = 32'h796b_730b;
		cycleCount = 0;
		checkCount = 0;
		errorCount = 0;
		@(posedge cclk);
		#1;
		rtypeTest("rtype", 0);
		itypeTest();
		loadStoreTest();
		branchTest();
		jumpTest();
		rtypeTest("host during run", 6);
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// ==== design/mipsSystem.sv ====
module mipsSystem (
	input logic cclk,
	input logic rstb,
	input mipsCtrlPkg::hostReq_t host,
	output mipsIsaPkg::word_t hostRdata
);
	import mipsIsaPkg::*;
	import mipsCtrlPkg::*;

	word_t instr;
	ctrlBundle_t ctrl;
	memReq_t cpuReq;
	memReq_t memReq;
	logic cpuStall;

	controlUnit controlUnit_i (
		.cclk(cclk),
		.rstb(rstb),
		.instr(instr),
		.cpuStall(cpuStall),
		.ctrl(ctrl)
	);

	// Core and host share one read bus
	datapath datapath_i (
		.cclk(cclk),
		.rstb(rstb),
		.ctrl(ctrl),
		.rdata(hostRdata),
		.memReq(cpuReq),
		.instr(instr)
	);

	memArbiter memArbiter_i (
		.host(host),
		.cpuReq(cpuReq),
		.cpuMemWrite(ctrl.memWrite),
		.memReq(memReq),
		.cpuStall(cpuStall)
	);

	unifiedMemory unifiedMemory_i (
		.cclk(cclk),
		.memReq(memReq),
		.rdata(hostRdata)
	);

endmodule

// ==== design/unifiedMemory.sv ====
module unifiedMemory (
	input logic cclk,
	input mipsCtrlPkg::memReq_t memReq,
	output mipsIsaPkg::word_t rdata
);
	import mipsIsaPkg::*;

	word_t mem [MemWords];

	always_ff @(posedge cclk) begin
		if (memReq.write) begin
			mem[memReq.addr] <= memReq.wdata;
		end
	end

	// Read data valid in the same cycle as the address
	assign rdata = mem[memReq.addr];

endmodule

// ==== design/memArbiter.sv ====
module memArbiter (
	input mipsCtrlPkg::hostReq_t host,
	input mipsCtrlPkg::memReq_t cpuReq,
	input logic cpuMemWrite,
	output mipsCtrlPkg::memReq_t memReq,
	output logic cpuStall
);

	// Host has fixed priority and stalls the core
	assign cpuStall = host.valid;

	always_comb begin
		if (host.valid) begin
			memReq.write = host.write;
			memReq.addr = host.addr;
			memReq.wdata = host.wdata;
		end else begin
			memReq.addr = cpuReq.addr;
			memReq.wdata = cpuReq.wdata;
			// Core store needs the FSM write enable as well
			memReq.write = cpuReq.write & cpuMemWrite;
		end
	end

endmodule

// ==== design/datapath.sv ====
module datapath (
	input logic cclk,
	input logic rstb,
	input mipsCtrlPkg::ctrlBundle_t ctrl,
	input mipsIsaPkg::word_t rdata,
	output mipsCtrlPkg::memReq_t memReq,
	output mipsIsaPkg::word_t instr
);
	import mipsIsaPkg::*;
	import mipsCtrlPkg::*;

	word_t pc, ir, mdr, regA, regB, aluOut;
	word_t regFile [32];
	word_t srcA, srcB, aluResult, immExt, pcNext, wrData, memAdr;
	logic [RegBits-1:0] rs, rt, rd, shamt, wrAddr;
	logic zero, pcEn;

	assign instr = ir;
	assign rs = ir[RsLsb +: RegBits];
	assign rt = ir[RtLsb +: RegBits];
	assign rd = ir[RdLsb +: RegBits];
	assign shamt = ir[ShamtLsb +: RegBits];
	assign immExt = {{(32 - ImmBits){ctrl.extSign & ir[ImmBits-1]}}, ir[ImmBits-1:0]};

	always_comb begin
		case (ctrl.aluSrcA)
			SrcAPc: srcA = pc;
			SrcAShamt: srcA = word_t'(shamt);
			default: srcA = regA;
		endcase
		case (ctrl.aluSrcB)
			SrcBFour: srcB = 32'd4;
			SrcBImm: srcB = immExt;
			SrcBImmShift: srcB = immExt << 2;
			default: srcB = regB;
		endcase
	end

	// Shifts move operand B by the amount on A
	always_comb begin
		case (ctrl.aluControl)
			AluSub: aluResult = srcA - srcB;
			AluAnd: aluResult = srcA & srcB;
			AluOr: aluResult = srcA | srcB;
			AluXor: aluResult = srcA ^ srcB;
			AluNor: aluResult = ~(srcA | srcB);
			AluSlt: aluResult = {31'b0, $signed(srcA) < $signed(srcB)};
			AluSll: aluResult = srcB << srcA[4:0];
			AluSrl: aluResult = srcB >> srcA[4:0];
			AluSra: aluResult = word_t'($signed(srcB) >>> srcA[4:0]);
			AluLui: aluResult = srcB << 16;
			default: aluResult = srcA + srcB;
		endcase
	end

	assign zero = (aluResult == '0);
	assign pcEn = ctrl.pcWrite | (ctrl.branch[0] & zero) | (ctrl.branch[1] & ~zero);

	always_comb begin
		case (ctrl.pcSrc)
			PcAluOut: pcNext = aluOut;
			PcJump: pcNext = {pc[31:28], ir[IndexBits-1:0], 2'b00};
			default: pcNext = aluResult;
		endcase
		case (ctrl.regDst)
			DstRd: wrAddr = rd;
			DstLink: wrAddr = RegLink;
			default: wrAddr = rt;
		endcase
	end

	// jal links the already incremented PC
	assign wrData = (ctrl.regDst == DstLink) ? pc : (ctrl.memToReg ? mdr : aluOut);

	always_ff @(posedge cclk) begin
		if (!rstb) begin
			pc <= '0;
		end else if (pcEn) begin
			pc <= pcNext;
		end
	end

	always_ff @(posedge cclk) begin
		if (ctrl.irWrite) begin
			ir <= rdata;
		end
		// Only data accesses refresh the load register
		if (ctrl.iOrD) begin
			mdr <= rdata;
		end
		// Branch target stays put while it is the PC source
		if (ctrl.pcSrc != PcAluOut) begin
			aluOut <= aluResult;
		end
		regA <= (rs == '0) ? '0 : regFile[rs];
		regB <= (rt == '0) ? '0 : regFile[rt];
		if (ctrl.regWrite) begin
			regFile[wrAddr] <= wrData;
		end
	end

	assign memAdr = ctrl.iOrD ? aluOut : pc;
	assign memReq.write = ctrl.memWrite;
	assign memReq.addr = memAdr[MemAddrBits+1:2];
	assign memReq.wdata = regB;

endmodule

// ==== design/controlUnit.sv ====
module controlUnit (
	input logic cclk,
	input logic rstb,
	input mipsIsaPkg::word_t instr,
	input logic cpuStall,
	output mipsCtrlPkg::ctrlBundle_t ctrl
);
	import mipsIsaPkg::*;
	import mipsCtrlPkg::*;

	ctrlState_e state;
	ctrlState_e nextState;
	opcode_e opcode;
	funct_e funct;
	aluOp_e aluOp;
	logic [CodeBits-1:0] aluCode;
	aluCtrl_e aluControl;
	ctrlBundle_t decoded;

	assign opcode = opcode_e'(instr[OpLsb +: CodeBits]);
	assign funct = funct_e'(instr[FunctLsb +: CodeBits]);

	// I-type classes decode on the opcode, the rest on funct
	assign aluCode = (aluOp == ItypeOp) ? instr[OpLsb +: CodeBits] : instr[FunctLsb +: CodeBits];

	aluDecoder aluDecoder_i (
		.aluOp(aluOp),
		.code(aluCode),
		.aluControl(aluControl)
	);

	always_comb begin
		nextState = state;
		case (state)
			PreFetch: nextState = Fetch;
			Fetch: nextState = Decode;
			Decode: begin
				case (opcode)
					Lw, Sw: nextState = MemAdr;
					RType: nextState = Execute;
					Beq, Bne: nextState = Branch;
					Addi, Slti, Andi, Ori, Xori, Lui: nextState = ItypeExecute;
					J: nextState = Jump;
					Jal: nextState = JalState;
					// Unknown opcodes fall through as a no-op
					default: nextState = PreFetch;
				endcase
			end
			MemAdr: nextState = (opcode == Sw) ? MemWrite : MemRead;
			MemRead: nextState = MemWriteback;
			Execute: nextState = (funct == Jr) ? JrState : AluWriteback;
			ItypeExecute: nextState = ItypeWriteback;
			default: nextState = PreFetch;
		endcase
	end

	always_ff @(posedge cclk) begin
		if (!rstb) begin
			state <= PreFetch;
		end else if (!cpuStall) begin
			state <= nextState;
		end
	end

	// Per-state selects and enables
	// Follow-on states repeat the ALU setup of the state before, so ALU-out
	// keeps its value when a cycle is repeated under stall
	always_comb begin
		decoded = '0;
		decoded.regDst = DstRt;
		decoded.pcSrc = PcAluResult;
		decoded.aluSrcA = SrcAPc;
		decoded.aluSrcB = SrcBFour;
		decoded.aluControl = AluAdd;
		// Logic immediates are zero extended
		decoded.extSign = !(opcode inside {Andi, Ori, Xori});
		aluOp = AddOp;
		case (state)
			PreFetch: begin
				decoded.irWrite = 1'b1;
				decoded.pcWrite = 1'b1;
			end
			Decode: begin
				// Branch target into ALU-out
				decoded.aluSrcB = SrcBImmShift;
			end
			MemAdr, MemRead, MemWriteback, MemWrite: begin
				decoded.aluSrcA = SrcARegA;
				decoded.aluSrcB = SrcBImm;
				decoded.iOrD = (state == MemRead) || (state == MemWrite);
				decoded.memWrite = (state == MemWrite);
				decoded.memToReg = (state == MemWriteback);
				decoded.regWrite = (state == MemWriteback);
			end
			Execute, AluWriteback, JrState: begin
				decoded.aluSrcA = (funct inside {Sll, Srl, Sra}) ? SrcAShamt : SrcARegA;
				decoded.aluSrcB = SrcBRegB;
				decoded.regDst = DstRd;
				decoded.regWrite = (state == AluWriteback);
				// jr target is register A passed through the adder
				decoded.pcWrite = (state == JrState);
				aluOp = FunctOp;
			end
			Branch: begin
				decoded.aluSrcA = SrcARegA;
				decoded.aluSrcB = SrcBRegB;
				decoded.pcSrc = PcAluOut;
				decoded.branch = {opcode == Bne, opcode == Beq};
				aluOp = SubOp;
			end
			ItypeExecute, ItypeWriteback: begin
				decoded.aluSrcA = SrcARegA;
				decoded.aluSrcB = SrcBImm;
				decoded.regWrite = (state == ItypeWriteback);
				aluOp = ItypeOp;
			end
			Jump: begin
				decoded.pcSrc = PcJump;
				decoded.pcWrite = 1'b1;
			end
			JalState: begin
				decoded.pcSrc = PcJump;
				decoded.pcWrite = 1'b1;
				decoded.regDst = DstLink;
				decoded.regWrite = 1'b1;
			end
			default: begin
			end
		endcase
	end

	always_comb begin
		ctrl = decoded;
		ctrl.aluControl = aluControl;
		// Host owns memory, freeze every architectural update
		if (cpuStall) begin
			ctrl.irWrite = 1'b0;
			ctrl.memWrite = 1'b0;
			ctrl.pcWrite = 1'b0;
			ctrl.regWrite = 1'b0;
			ctrl.branch = 2'b00;
		end
	end

endmodule

// ==== design/aluDecoder.sv ====
module aluDecoder (
	input mipsCtrlPkg::aluOp_e aluOp,
	input logic [5:0] code,
	output mipsCtrlPkg::aluCtrl_e aluControl
);
	import mipsIsaPkg::*;
	import mipsCtrlPkg::*;

	always_comb begin
		aluControl = AluAdd;
		case (aluOp)
			AddOp: aluControl = AluAdd;
			SubOp: aluControl = AluSub;
			FunctOp: begin
				case (funct_e'(code))
					Add: aluControl = AluAdd;
					Sub: aluControl = AluSub;
					And: aluControl = AluAnd;
					Or: aluControl = AluOr;
					Xor: aluControl = AluXor;
					Nor: aluControl = AluNor;
					Slt: aluControl = AluSlt;
					Sll: aluControl = AluSll;
					Srl: aluControl = AluSrl;
					Sra: aluControl = AluSra;
					// jr adds register A and the zero rt
					default: aluControl = AluAdd;
				endcase
			end
			ItypeOp: begin
				case (opcode_e'(code))
					Slti: aluControl = AluSlt;
					Andi: aluControl = AluAnd;
					Ori: aluControl = AluOr;
					Xori: aluControl = AluXor;
					Lui: aluControl = AluLui;
					default: aluControl = AluAdd;
				endcase
			end
			default: aluControl = AluAdd;
		endcase
	end

endmodule

// ==== design/mipsCtrlPkg.sv ====
package mipsCtrlPkg;

	// Multicycle FSM states
	typedef enum logic [4:0] {
		PreFetch, Fetch, Decode,
		MemAdr, MemRead, MemWriteback, MemWrite,
		Execute, AluWriteback, Branch,
		ItypeExecute, ItypeWriteback,
		Jump, JrState, JalState
	} ctrlState_e;

	// Operation class handed to the ALU decoder
	typedef enum logic [1:0] {AddOp, SubOp, FunctOp, ItypeOp} aluOp_e;

	typedef enum logic [3:0] {
		AluAdd, AluSub, AluAnd, AluOr, AluXor, AluNor,
		AluSlt, AluSll, AluSrl, AluSra, AluLui
	} aluCtrl_e;

	typedef enum logic [1:0] {SrcAPc, SrcARegA, SrcAShamt} srcA_e;
	typedef enum logic [1:0] {SrcBRegB, SrcBFour, SrcBImm, SrcBImmShift} srcB_e;
	typedef enum logic [1:0] {PcAluResult, PcAluOut, PcJump} pcSrc_e;
	typedef enum logic [1:0] {DstRt, DstRd, DstLink} regDst_e;

	typedef struct packed {
		logic     memToReg;
		logic     iOrD;
		regDst_e  regDst;
		pcSrc_e   pcSrc;
		srcA_e    aluSrcA;
		srcB_e    aluSrcB;
		// Bit 1 bne, bit 0 beq
		logic [1:0] branch;
		logic     irWrite;
		logic     memWrite;
		logic     pcWrite;
		logic     regWrite;
		logic     extSign;
		aluCtrl_e aluControl;
	} ctrlBundle_t;

	// Host side memory request
	typedef struct packed {
		logic                             valid;
		logic                             write;
		logic [mipsIsaPkg::MemAddrBits-1:0] addr;
		mipsIsaPkg::word_t                wdata;
	} hostReq_t;

	typedef struct packed {
		logic                             write;
		logic [mipsIsaPkg::MemAddrBits-1:0] addr;
		mipsIsaPkg::word_t                wdata;
	} memReq_t;

endpackage

// ==== design/mipsIsaPkg.sv ====
package mipsIsaPkg;

	// Machine word
	typedef logic [31:0] word_t;

	// Memory geometry, word addressed
	localparam int MemWords = 256;
	localparam int MemAddrBits = 8;

	// Return address register for jal
	localparam logic [4:0] RegLink = 5'd31;

	// Instruction field positions
	localparam int OpLsb = 26;
	localparam int RsLsb = 21;
	localparam int RtLsb = 16;
	localparam int RdLsb = 11;
	localparam int ShamtLsb = 6;
	localparam int FunctLsb = 0;
	localparam int CodeBits = 6;
	localparam int RegBits = 5;
	localparam int ImmBits = 16;
	localparam int IndexBits = 26;

	// Primary opcodes
	typedef enum logic [5:0] {
		RType = 6'h00,
		J     = 6'h02,
		Jal   = 6'h03,
		Beq   = 6'h04,
		Bne   = 6'h05,
		Addi  = 6'h08,
		Slti  = 6'h0a,
		Andi  = 6'h0c,
		Ori   = 6'h0d,
		Xori  = 6'h0e,
		Lui   = 6'h0f,
		Lw    = 6'h23,
		Sw    = 6'h2b
	} opcode_e;

	// Function codes of R-type instructions
	typedef enum logic [5:0] {
		Sll = 6'h00,
		Srl = 6'h02,
		Sra = 6'h03,
		Jr  = 6'h08,
		Add = 6'h20,
		Sub = 6'h22,
		And = 6'h24,
		Or  = 6'h25,
		Xor = 6'h26,
		Nor = 6'h27,
		Slt = 6'h2a
	} funct_e;

endpackage
